//--- cpu.f
+incdir+.
cpuPkg.sv
instrDecoder.sv
coreControl.sv
pcUnit.sv
regFile.sv
execUnit.sv
busUnit.sv
cpu.sv
cpuMemModel.sv
cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - files:
      - cpuPkg.sv
      - instrDecoder.sv
      - coreControl.sv
      - pcUnit.sv
      - regFile.sv
      - execUnit.sv
      - busUnit.sv
      - cpu.sv
  - target: test
    files:
      - cpuMemModel.sv
      - cpu_tb.sv

//--- cpu_tb.sv
// tb_cpu: clock, reset, test programs, bus monitor, store checks and final report
`timescale 1ns/100ps
`include "cpu_consts.svh"

module tb_cpu;

	logic clk;
	logic rstN;
	logic hlt;
	logic [`CPU_XLEN-1:0] pc;
	logic memReqValid, memReqReady, memRspValid;
	cpuPkg::busReq memReq;
	cpuPkg::busRsp memRsp;

	logic [`CPU_XLEN-1:0] asmAddr; // next free program address
	logic [`CPU_XLEN-1:0] haltAddr;
	logic [3:0] caseIdx; // marker slot of the next branch case
	logic [31:0] expStores [$]; // {addr, wdata} in bus order
	int errCount, testStartErrs, testsPassed, testsFailed;
	int stallCycles, stallErrs;
	logic firstPending, prevValid, prevReady;
	logic resetSeen; // last rising edge was still in reset
	cpuPkg::busReq prevReq;

	cpu uut (.clk(clk), .rstN(rstN), .hlt(hlt), .pc(pc), .memReqValid(memReqValid),
		.memReqReady(memReqReady), .memReq(memReq), .memRspValid(memRspValid),
		.memRsp(memRsp));

	cpuMemModel memModel (.clk(clk), .rstN(rstN), .memReqValid(memReqValid),
		.memReqReady(memReqReady), .memReq(memReq), .memRspValid(memRspValid),
		.memRsp(memRsp));

	always #4 clk = ~clk;

	function automatic logic [15:0] fillWord(input logic [15:0] addr);
		fillWord = (addr * 16'h9e37) ^ 16'h3c5a; // odd multiplier, every bit matters
	endfunction

	task automatic checkValue(input string name, input logic [15:0] exp, input logic [15:0] got);
		assert (got === exp) else begin
			$display("ERROR %s: expected %h, got %h", name, exp, got);
			errCount++;
		end
	endtask

	task automatic emit(input logic [3:0] op, input logic [3:0] x, input logic [7:0] lo);
		memModel.words[asmAddr[15:1]] = {op, x, lo};
		asmAddr = asmAddr + 16'd2;
	endtask

	task automatic emitHalt();
		haltAddr = asmAddr;
		emit(`CPU_OP_HLT, 4'h0, 8'h00);
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
		expStores.push_back({addr, data});
	endtask

	// B over one marker store, marker kept only on fall-through
	task automatic branchCase(input logic [2:0] cond, input logic taken);
		emit(`CPU_OP_B, {cond, 1'b0}, 8'h01);
		emit(`CPU_OP_SW, 4'd11, {4'd1, caseIdx});
		if (!taken)
			expectStore(16'h0300 + {caseIdx, 1'b0}, 16'h00AA);
		caseIdx++;
	endtask

	task automatic startProgram();
		@(negedge clk);
		rstN = 1'b0;
		for (int i = 0; i < 32768; i++)
			memModel.words[i] = fillWord(16'(2 * i));
		asmAddr = '0;
		caseIdx = '0;
		expStores.delete();
	endtask

	task automatic releaseReset();
		for (int i = 0; i < 2; i++) begin
			@(negedge clk);
			checkValue("memReqValid", 16'h0, memReqValid);
			checkValue("hlt", 16'h0, hlt);
		end
		rstN = 1'b1; // values above hold until the first rising edge out of reset
	endtask

	task automatic finishProgram();
		int cycles;
		cycles = 0;
		while (!hlt && cycles < 4000) begin
			@(negedge clk);
			cycles++;
		end
		assert (hlt) else begin
			$display("timeout: hlt did not rise within 4000 cycles");
			errCount++;
		end
		assert (memModel.wrCount == expStores.size()) else begin
			$display("store count wrong: expected %0d, got %0d", expStores.size(),
				memModel.wrCount);
			errCount++;
		end
		for (int i = 0; i < expStores.size() && i < memModel.wrCount; i++) begin
			checkValue("memReq.addr", expStores[i][31:16], memModel.wrLog[i][31:16]);
			checkValue("memReq.wdata", expStores[i][15:0], memModel.wrLog[i][15:0]);
		end
	endtask

	task automatic endTest(input string name);
		if (errCount == testStartErrs) begin
			$display("test %s: pass", name);
			testsPassed++;
		end else begin
			$display("test %s: FAIL, %0d errors", name, errCount - testStartErrs);
			testsFailed++;
		end
		testStartErrs = errCount;
	endtask

	// bus monitor, samples like a flop on the rising edge
	always @(posedge clk) begin
		if (!rstN) begin
			firstPending = 1'b1;
			prevValid = 1'b0;
			resetSeen = 1'b1;
		end else begin
			if (resetSeen) begin // first cycle out of reset
				checkValue("memReqValid", 16'h0, memReqValid);
				checkValue("hlt", 16'h0, hlt);
				resetSeen = 1'b0;
			end
			if (prevValid && !prevReady) begin // stalled last cycle
				stallCycles++;
				assert (memReqValid === 1'b1 && memReq === prevReq) else begin
					$display("ERROR memReq: expected %h, got %h (memReqValid %h)",
						prevReq, memReq, memReqValid);
					stallErrs++;
				end
			end
			if (memReqValid && memReqReady && firstPending) begin
				firstPending = 1'b0;
				checkValue("memReq.addr", 16'h0000, memReq.addr);
				checkValue("memReq.write", 16'h0, memReq.write);
			end
			prevValid = memReqValid;
			prevReady = memReqReady;
			prevReq = memReq;
		end
	end

	initial begin
		int cycles;
		logic [15:0] w0, w1, w2, tgt;
		clk = 1'b0;
		rstN = 1'b0;
		errCount = 0;
		testStartErrs = 0;
		testsPassed = 0;
		testsFailed = 0;
		stallCycles = 0;
		stallErrs = 0;
		firstPending = 1'b1;
		prevValid = 1'b0;
		prevReady = 1'b0;
		resetSeen = 1'b0;
		prevReq = '0;

		// arithmetic, results stored from 0x0100
		startProgram();
		emit(`CPU_OP_LHB, 4'd1, 8'h01); // r1 = 0100
		emit(`CPU_OP_LLB, 4'd2, 8'hF0);
		emit(`CPU_OP_LHB, 4'd2, 8'h7F); // r2 = 7ff0
		emit(`CPU_OP_LLB, 4'd3, 8'h25); // r3 = 0025
		emit(`CPU_OP_ADD, 4'd4, 8'h23); // signed overflow
		emit(`CPU_OP_SW, 4'd4, 8'h10);
		emit(`CPU_OP_SUB, 4'd5, 8'h32);
		emit(`CPU_OP_SW, 4'd5, 8'h11);
		emit(`CPU_OP_XOR, 4'd6, 8'h23);
		emit(`CPU_OP_SW, 4'd6, 8'h12);
		emit(`CPU_OP_SLL, 4'd7, 8'h34); // r3 << 4
		emit(`CPU_OP_SW, 4'd7, 8'h13);
		emit(`CPU_OP_SRA, 4'd8, 8'h43); // r4 >>> 3, sign fill
		emit(`CPU_OP_SW, 4'd8, 8'h14);
		emit(`CPU_OP_ADD, 4'd9, 8'h44); // carry out dropped
		emit(`CPU_OP_SW, 4'd9, 8'h15);
		emit(`CPU_OP_LHB, 4'd3, 8'hC3);
		emit(`CPU_OP_SW, 4'd3, 8'h16);
		emit(`CPU_OP_LLB, 4'd4, 8'h99); // upper byte of r4 stays
		emit(`CPU_OP_SW, 4'd4, 8'h17);
		emitHalt();
		expectStore(16'h0100, 16'h8015);
		expectStore(16'h0102, 16'h8035);
		expectStore(16'h0104, 16'h7FD5);
		expectStore(16'h0106, 16'h0250);
		expectStore(16'h0108, 16'hF002);
		expectStore(16'h010A, 16'h002A);
		expectStore(16'h010C, 16'hC325);
		expectStore(16'h010E, 16'h8099);
		releaseReset();
		cycles = 0;
		while (firstPending && cycles < 100) begin
			@(negedge clk);
			cycles++;
		end
		assert (!firstPending) else begin
			$display("timeout: no request accepted after reset");
			errCount++;
		end
		endTest("reset and first fetch");
		finishProgram();
		endTest("arithmetic");

		// loads of stored and preloaded words, sums stored back
		startProgram();
		w0 = fillWord(16'h0200);
		w1 = fillWord(16'h0202);
		w2 = fillWord(16'h021E);
		emit(`CPU_OP_LHB, 4'd1, 8'h02); // r1 = 0200
		emit(`CPU_OP_LLB, 4'd2, 8'h34);
		emit(`CPU_OP_LHB, 4'd2, 8'h12);
		emit(`CPU_OP_SW, 4'd2, 8'h18);
		emit(`CPU_OP_LW, 4'd3, 8'h18); // reads back the store
		emit(`CPU_OP_LW, 4'd4, 8'h10);
		emit(`CPU_OP_LW, 4'd5, 8'h11);
		emit(`CPU_OP_ADD, 4'd6, 8'h34);
		emit(`CPU_OP_SW, 4'd6, 8'h19);
		emit(`CPU_OP_ADD, 4'd7, 8'h45);
		emit(`CPU_OP_SW, 4'd7, 8'h1A);
		emit(`CPU_OP_LW, 4'd8, 8'h1F); // largest offset
		emit(`CPU_OP_SW, 4'd8, 8'h1B);
		emitHalt();
		expectStore(16'h0210, 16'h1234);
		expectStore(16'h0212, 16'h1234 + w0);
		expectStore(16'h0214, w0 + w1);
		expectStore(16'h0216, w2);
		releaseReset();
		finishProgram();
		endTest("load and store");

		// every condition taken and not taken, then BR
		startProgram();
		emit(`CPU_OP_LHB, 4'd1, 8'h03); // r1 = 0300 marker slots
		emit(`CPU_OP_LHB, 4'd2, 8'h04); // r2 = 0400
		emit(`CPU_OP_LLB, 4'd3, 8'h10);
		emit(`CPU_OP_LLB, 4'd4, 8'h20);
		emit(`CPU_OP_LLB, 4'd10, 8'hF0);
		emit(`CPU_OP_LHB, 4'd10, 8'h7F);
		emit(`CPU_OP_LLB, 4'd11, 8'hAA); // marker value
		emit(`CPU_OP_SUB, 4'd5, 8'h33); // zero
		branchCase(`CPU_COND_NE, 1'b0);
		branchCase(`CPU_COND_EQ, 1'b1);
		branchCase(`CPU_COND_GE, 1'b1);
		branchCase(`CPU_COND_OV, 1'b0);
		emit(`CPU_OP_SUB, 4'd5, 8'h43); // positive
		branchCase(`CPU_COND_NE, 1'b1);
		branchCase(`CPU_COND_EQ, 1'b0);
		branchCase(`CPU_COND_GT, 1'b1);
		branchCase(`CPU_COND_LT, 1'b0);
		branchCase(`CPU_COND_LE, 1'b0);
		emit(`CPU_OP_SUB, 4'd5, 8'h34); // negative, no overflow
		branchCase(`CPU_COND_GT, 1'b0);
		branchCase(`CPU_COND_LT, 1'b1);
		branchCase(`CPU_COND_GE, 1'b0);
		branchCase(`CPU_COND_LE, 1'b1);
		emit(`CPU_OP_ADD, 4'd5, 8'hA3); // 7ff0 + 0010 sets v
		branchCase(`CPU_COND_OV, 1'b1);
		emit(`CPU_OP_XOR, 4'd6, 8'h33); // z only, v untouched
		branchCase(`CPU_COND_OV, 1'b1);
		branchCase(`CPU_COND_UN, 1'b1);
		tgt = asmAddr + 16'd8; // past LLB, LHB, BR and the skipped store
		emit(`CPU_OP_LLB, 4'd12, tgt[7:0]);
		emit(`CPU_OP_LHB, 4'd12, tgt[15:8]);
		emit(`CPU_OP_BR, {`CPU_COND_UN, 1'b0}, 8'hC0);
		emit(`CPU_OP_SW, 4'd11, 8'h21); // wrong path
		emit(`CPU_OP_SW, 4'd12, 8'h20);
		emitHalt();
		expectStore(16'h0400, tgt);
		releaseReset();
		finishProgram();
		endTest("branches");

		assert (stallCycles > 0) else begin
			$display("no stalled request was seen");
			errCount++;
		end
		errCount += stallErrs;
		endTest("request held under back-pressure");

		checkValue("pc", haltAddr, pc);
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			checkValue("memReqValid", 16'h0, memReqValid);
			checkValue("hlt", 16'h1, hlt);
			checkValue("pc", haltAddr, pc);
		end
		endTest("halt");

		$display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
		if (errCount == 0 && testsFailed == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- cpuMemModel.sv
// cpuMemModel: word memory with random ready, random response delay and a store log
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuMemModel (
	input logic clk,
	input logic rstN,
	input logic memReqValid,
	output logic memReqReady,
	input cpuPkg::busReq memReq,
	output logic memRspValid,
	output cpuPkg::busRsp memRsp
);

	logic [`CPU_XLEN-1:0] words [32768]; // indexed by byte address >> 1
	logic [31:0] wrLog [256]; // {addr, wdata} per accepted store
	int wrCount;
	integer seed;
	int rspWait; // falling edges left until the strobe, -1 when idle
	logic [`CPU_XLEN-1:0] rspData;
	logic nextReady;
	logic inReset; // rstN as seen by the last rising edge

	initial begin
		seed = 32'h4d2f;
		memReqReady = 1'b0;
		memRspValid = 1'b0;
		memRsp = '0;
		wrCount = 0;
		rspWait = -1;
		inReset = 1'b1;
	end

	always @(posedge clk)
		inReset <= !rstN;

	// all outputs change on the falling edge
	always @(negedge clk) begin
		memRspValid = 1'b0;
		if (inReset) begin
			memReqReady = 1'b0;
			wrCount = 0;
			rspWait = -1;
		end else begin
			if (rspWait == 0) begin
				memRspValid = 1'b1; // one-cycle strobe
				memRsp.rdata = rspData;
			end
			if (rspWait >= 0)
				rspWait = rspWait - 1;
			nextReady = $random(seed) & 1;
			memReqReady = nextReady;
			if (memReqValid && nextReady) begin // transfers at the coming rising edge
				if (memReq.write) begin
					words[memReq.addr[15:1]] = memReq.wdata;
					if (wrCount < 256)
						wrLog[wrCount] = {memReq.addr, memReq.wdata};
					wrCount++;
				end else begin
					rspData = words[memReq.addr[15:1]];
				end
				rspWait = $random(seed) & 3; // 0..3 extra cycles
			end
		end
	end

endmodule

//--- cpu.sv
// cpu: top level wiring of control, pc, decoder, register file, ALU and bus
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpu (
	input logic clk,
	input logic rstN,
	output logic hlt,
	output logic [`CPU_XLEN-1:0] pc,
	output logic memReqValid,
	input logic memReqReady,
	output cpuPkg::busReq memReq,
	input logic memRspValid,
	input cpuPkg::busRsp memRsp
);

	cpuPkg::instrWord instr;
	cpuPkg::ctrlSig ctrl;
	logic issueFetch, issueData, capture; // bus steps
	logic execEn, wbEn;
	logic pcAdvance, pcBranch;
	logic branchTaken;
	logic [`CPU_XLEN-1:0] rdA, rdB;
	logic [`CPU_XLEN-1:0] result;
	logic [`CPU_XLEN-1:0] wbData;

	coreControl uCtrl (.clk(clk), .rstN(rstN), .ctrl(ctrl), .branchTaken(branchTaken),
		.memReqReady(memReqReady), .memRspValid(memRspValid),
		.issueFetch(issueFetch), .issueData(issueData), .capture(capture),
		.execEn(execEn), .wbEn(wbEn), .pcAdvance(pcAdvance), .pcBranch(pcBranch),
		.hlt(hlt));

	pcUnit uPc (.clk(clk), .rstN(rstN), .pcAdvance(pcAdvance), .pcBranch(pcBranch),
		.ctrl(ctrl), .regTarget(rdA), .pc(pc)); // BR target from rs

	instrDecoder uDec (.instr(instr), .ctrl(ctrl));

	regFile uRegs (.clk(clk), .rstN(rstN), .ctrl(ctrl), .wbEn(wbEn), .wbData(wbData),
		.rdA(rdA), .rdB(rdB));

	execUnit uExec (.clk(clk), .rstN(rstN), .execEn(execEn), .ctrl(ctrl),
		.rdA(rdA), .rdB(rdB), .result(result), .branchTaken(branchTaken));

	busUnit uBus (.clk(clk), .rstN(rstN), .issueFetch(issueFetch), .issueData(issueData),
		.capture(capture), .pc(pc), .ctrl(ctrl), .result(result), .rdB(rdB),
		.memReqReady(memReqReady), .memRsp(memRsp), .memReqValid(memReqValid),
		.memReq(memReq), .instr(instr), .wbData(wbData));

endmodule

//--- busUnit.sv
// busUnit: request register, instruction and load-data capture, writeback mux
`timescale 1ns/100ps
`include "cpu_consts.svh"

module busUnit (
	input logic clk,
	input logic rstN,
	input logic issueFetch,
	input logic issueData,
	input logic capture,
	input logic [`CPU_XLEN-1:0] pc,
	input cpuPkg::ctrlSig ctrl,
	input logic [`CPU_XLEN-1:0] result,
	input logic [`CPU_XLEN-1:0] rdB,
	input logic memReqReady,
	input cpuPkg::busRsp memRsp,
	output logic memReqValid,
	output cpuPkg::busReq memReq,
	output cpuPkg::instrWord instr,
	output logic [`CPU_XLEN-1:0] wbData
);

	logic dataPhase; // outstanding request is a data access
	logic [`CPU_XLEN-1:0] loadData;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			memReqValid <= 1'b0;
			dataPhase <= 1'b0;
		end else if (issueFetch || issueData) begin
			memReqValid <= 1'b1;
			dataPhase <= issueData;
		end else if (memReqValid && memReqReady) begin
			memReqValid <= 1'b0; // accepted
		end
	end

	// held stable until accepted
	always_ff @(posedge clk) begin
		if (issueFetch) begin
			memReq.addr <= pc;
			memReq.wdata <= '0;
			memReq.write <= 1'b0;
		end else if (issueData) begin
			memReq.addr <= result; // computed address
			memReq.wdata <= rdB;
			memReq.write <= ctrl.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		if (capture && !dataPhase)
			instr <= memRsp.rdata;
		if (capture && dataPhase)
			loadData <= memRsp.rdata;
	end

	assign wbData = ctrl.memRead ? loadData : result;

endmodule

//--- execUnit.sv
// execUnit: ALU, z/v/n flag register, branch condition and result register
`timescale 1ns/100ps
`include "cpu_consts.svh"

module execUnit (
	input logic clk,
	input logic rstN,
	input logic execEn,
	input cpuPkg::ctrlSig ctrl,
	input logic [`CPU_XLEN-1:0] rdA,
	input logic [`CPU_XLEN-1:0] rdB,
	output logic [`CPU_XLEN-1:0] result,
	output logic branchTaken
);

	logic [`CPU_XLEN-1:0] opB;
	logic [`CPU_XLEN-1:0] addRes;
	logic [`CPU_XLEN-1:0] subRes;
	logic [`CPU_XLEN-1:0] aluOut;
	logic [2:0] newFlags; // {z, v, n}
	logic [2:0] flags;
	logic condMet;

	assign opB = ctrl.useImm ? ctrl.imm : rdB;
	assign addRes = rdA + opB; // wraps
	assign subRes = rdA - opB;

	always_comb begin
		case (ctrl.opcode)
			`CPU_OP_ADD: aluOut = addRes;
			`CPU_OP_SUB: aluOut = subRes;
			`CPU_OP_XOR: aluOut = rdA ^ opB;
			`CPU_OP_SLL: aluOut = rdA << opB[3:0];
			`CPU_OP_SRA: aluOut = $signed(rdA) >>> opB[3:0];
			`CPU_OP_LW, `CPU_OP_SW: aluOut = addRes; // rs + offset
			`CPU_OP_LLB: aluOut = {rdB[15:8], ctrl.imm[7:0]};
			`CPU_OP_LHB: aluOut = {ctrl.imm[7:0], rdB[7:0]};
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		newFlags[`CPU_FLAG_Z] = (aluOut == '0);
		newFlags[`CPU_FLAG_N] = aluOut[`CPU_XLEN-1];
		if (ctrl.opcode == `CPU_OP_SUB) // operand signs differ, sign flips
			newFlags[`CPU_FLAG_V] = (rdA[15] != opB[15]) && (subRes[15] != rdA[15]);
		else // same-sign add overflow
			newFlags[`CPU_FLAG_V] = (rdA[15] == opB[15]) && (addRes[15] != rdA[15]);
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			flags <= '0;
		else if (execEn)
			flags <= (flags & ~ctrl.flagWrite) | (newFlags & ctrl.flagWrite);
	end

	always_ff @(posedge clk) begin
		if (execEn)
			result <= aluOut;
	end

	always_comb begin
		case (ctrl.cond) // stored flags from earlier ops
			`CPU_COND_NE: condMet = !flags[`CPU_FLAG_Z];
			`CPU_COND_EQ: condMet = flags[`CPU_FLAG_Z];
			`CPU_COND_GT: condMet = !flags[`CPU_FLAG_Z] && !flags[`CPU_FLAG_N];
			`CPU_COND_LT: condMet = flags[`CPU_FLAG_N];
			`CPU_COND_GE: condMet = flags[`CPU_FLAG_Z] || !flags[`CPU_FLAG_N];
			`CPU_COND_LE: condMet = flags[`CPU_FLAG_Z] || flags[`CPU_FLAG_N];
			`CPU_COND_OV: condMet = flags[`CPU_FLAG_V];
			default: condMet = 1'b1; // unconditional
		endcase
	end

	assign branchTaken = ctrl.isBranch && condMet;

endmodule

//--- regFile.sv
// regFile: 16x16 registers, two combinational reads, one write, r0 reads zero
`timescale 1ns/100ps
`include "cpu_consts.svh"

module regFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlSig ctrl,
	input logic wbEn,
	input logic [`CPU_XLEN-1:0] wbData,
	output logic [`CPU_XLEN-1:0] rdA,
	output logic [`CPU_XLEN-1:0] rdB
);

	logic [`CPU_XLEN-1:0] regs [`CPU_REGS];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `CPU_REGS; i++)
				regs[i] <= '0;
		end else if (wbEn && ctrl.regWrite && ctrl.rd != '0) begin
			regs[ctrl.rd] <= wbData; // r0 never written
		end
	end

	assign rdA = (ctrl.rsA == '0) ? '0 : regs[ctrl.rsA];
	assign rdB = (ctrl.rsB == '0) ? '0 : regs[ctrl.rsB];

endmodule

//--- pcUnit.sv
// pcUnit: program counter with +2, relative branch and register target
`timescale 1ns/100ps
`include "cpu_consts.svh"

module pcUnit (
	input logic clk,
	input logic rstN,
	input logic pcAdvance,
	input logic pcBranch,
	input cpuPkg::ctrlSig ctrl,
	input logic [`CPU_XLEN-1:0] regTarget,
	output logic [`CPU_XLEN-1:0] pc
);

	logic [`CPU_XLEN-1:0] pcNext;
	logic [`CPU_XLEN-1:0] brTarget;

	assign pcNext = pc + `CPU_XLEN'd2;
	// B is relative to the following instruction
	assign brTarget = ctrl.isBranchReg ? regTarget : pcNext + (ctrl.imm << 1);

	always_ff @(posedge clk) begin
		if (!rstN)
			pc <= '0;
		else if (pcBranch)
			pc <= brTarget;
		else if (pcAdvance)
			pc <= pcNext;
	end

endmodule

//--- coreControl.sv
// coreControl: fetch, decode, execute, memory and writeback sequencing FSM
`timescale 1ns/100ps

module coreControl (
	input logic clk,
	input logic rstN,
	input cpuPkg::ctrlSig ctrl,
	input logic branchTaken,
	input logic memReqReady,
	input logic memRspValid,
	output logic issueFetch,
	output logic issueData,
	output logic capture,
	output logic execEn,
	output logic wbEn,
	output logic pcAdvance,
	output logic pcBranch,
	output logic hlt
);

	cpuPkg::ctrlState state, stateNext;
	logic reqSent; // request loaded, waiting for ready

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= cpuPkg::FETCH;
			reqSent <= 1'b0;
		end else begin
			state <= stateNext;
			if (issueFetch || issueData)
				reqSent <= 1'b1;
			else if (memReqReady)
				reqSent <= 1'b0; // handshake done this edge
		end
	end

	always_comb begin
		stateNext = state;
		issueFetch = 1'b0;
		issueData = 1'b0;
		capture = 1'b0;
		execEn = 1'b0;
		wbEn = 1'b0;
		pcAdvance = 1'b0;
		pcBranch = 1'b0;
		case (state)
			cpuPkg::FETCH: begin
				issueFetch = !reqSent; // first cycle only
				if (reqSent && memReqReady)
					stateNext = cpuPkg::FETCHWAIT;
			end
			cpuPkg::FETCHWAIT: begin
				capture = memRspValid;
				if (memRspValid)
					stateNext = cpuPkg::DECODE;
			end
			cpuPkg::DECODE: begin
				stateNext = ctrl.isHalt ? cpuPkg::HALT : cpuPkg::EXECUTE;
			end
			cpuPkg::EXECUTE: begin
				execEn = 1'b1;
				pcBranch = branchTaken;
				pcAdvance = !branchTaken;
				if (ctrl.memRead || ctrl.memWrite)
					stateNext = cpuPkg::MEMREQ;
				else
					stateNext = cpuPkg::WRITEBACK;
			end
			cpuPkg::MEMREQ: begin
				issueData = !reqSent;
				if (reqSent && memReqReady)
					stateNext = cpuPkg::MEMWAIT;
			end
			cpuPkg::MEMWAIT: begin
				capture = memRspValid; // stores get a response too
				if (memRspValid)
					stateNext = cpuPkg::WRITEBACK;
			end
			cpuPkg::WRITEBACK: begin
				wbEn = 1'b1;
				stateNext = cpuPkg::FETCH;
			end
			default: stateNext = cpuPkg::HALT; // parked for good
		endcase
	end

	assign hlt = (state == cpuPkg::HALT);

endmodule

//--- instrDecoder.sv
// instrDecoder: opcode to control signals, register ids and immediate
`timescale 1ns/100ps
`include "cpu_consts.svh"

module instrDecoder (
	input cpuPkg::instrWord instr,
	output cpuPkg::ctrlSig ctrl
);

	always_comb begin
		ctrl = '0;
		ctrl.opcode = instr.rFmt.opcode;
		ctrl.cond = instr.bFmt.cond; // only meaningful for B/BR
		ctrl.rd = instr.rFmt.rd;
		ctrl.rsA = instr.rFmt.rs;
		ctrl.rsB = instr.rFmt.rt;
		case (instr.rFmt.opcode)
			`CPU_OP_ADD, `CPU_OP_SUB: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite = 3'b111; // z v n
			end
			`CPU_OP_XOR: begin
				ctrl.regWrite = 1'b1;
				ctrl.flagWrite[`CPU_FLAG_Z] = 1'b1;
			end
			`CPU_OP_SLL, `CPU_OP_SRA: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.imm = {{(`CPU_XLEN-4){1'b0}}, instr.rFmt.rt}; // shift amount
				ctrl.flagWrite[`CPU_FLAG_Z] = 1'b1;
			end
			`CPU_OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.imm = {{(`CPU_XLEN-5){1'b0}}, instr.rFmt.rt, 1'b0}; // word to byte
			end
			`CPU_OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.imm = {{(`CPU_XLEN-5){1'b0}}, instr.rFmt.rt, 1'b0};
				ctrl.rsB = instr.rFmt.rd; // store data from rd
			end
			`CPU_OP_LLB, `CPU_OP_LHB: begin
				ctrl.regWrite = 1'b1;
				ctrl.useImm = 1'b1;
				ctrl.imm = {{(`CPU_XLEN-8){1'b0}}, instr.iFmt.imm8};
				ctrl.rsB = instr.iFmt.rd; // old rd keeps the other byte
			end
			`CPU_OP_B: begin
				ctrl.isBranch = 1'b1;
				ctrl.imm = {{(`CPU_XLEN-9){instr.bFmt.imm9[8]}}, instr.bFmt.imm9};
			end
			`CPU_OP_BR: begin
				ctrl.isBranch = 1'b1;
				ctrl.isBranchReg = 1'b1; // target from rs
			end
			`CPU_OP_HLT: ctrl.isHalt = 1'b1;
			default: ; // unused opcodes run as no-ops
		endcase
	end

endmodule

//--- cpuPkg.sv
// instruction union, decoded control struct, bus structs and the FSM state enum
`include "cpu_consts.svh"

package cpuPkg;

	// register format, also LW/SW with rt as word offset
	typedef struct packed {
		logic [`CPU_OPW-1:0] opcode;
		logic [`CPU_RIDW-1:0] rd;
		logic [`CPU_RIDW-1:0] rs;
		logic [`CPU_RIDW-1:0] rt; // second source or shift amount
	} rFields;

	typedef struct packed {
		logic [`CPU_OPW-1:0] opcode;
		logic [`CPU_RIDW-1:0] rd;
		logic [7:0] imm8; // LLB/LHB byte
	} iFields;

	typedef struct packed {
		logic [`CPU_OPW-1:0] opcode;
		logic [2:0] cond;
		logic [8:0] imm9; // signed word offset
	} bFields;

	// one fetched word, three views
	typedef union packed {
		rFields rFmt;
		iFields iFmt;
		bFields bFmt;
	} instrWord;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch; // B or BR
		logic isBranchReg; // BR only
		logic isHalt;
		logic useImm; // operand b from imm
		logic [2:0] flagWrite; // {z, v, n} enables
		logic [`CPU_OPW-1:0] opcode;
		logic [2:0] cond;
		logic [`CPU_RIDW-1:0] rd;
		logic [`CPU_RIDW-1:0] rsA;
		logic [`CPU_RIDW-1:0] rsB;
		logic [`CPU_XLEN-1:0] imm;
	} ctrlSig;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wdata;
		logic write;
	} busReq;

	typedef struct packed {
		logic [`CPU_XLEN-1:0] rdata;
	} busRsp;

	typedef enum logic [2:0] {
		FETCH,
		FETCHWAIT,
		DECODE,
		EXECUTE,
		MEMREQ,
		MEMWAIT,
		WRITEBACK,
		HALT
	} ctrlState;

endpackage

//--- cpu_consts.svh
// widths, opcodes, branch conditions and flag bit positions
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_XLEN 16 // data and address width
`define CPU_REGS 16 // register count
`define CPU_OPW 4 // opcode width
`define CPU_RIDW 4 // register id width

`define CPU_OP_ADD 4'h0
`define CPU_OP_SUB 4'h1
`define CPU_OP_XOR 4'h2
`define CPU_OP_SLL 4'h4
`define CPU_OP_SRA 4'h5
`define CPU_OP_LW 4'h8
`define CPU_OP_SW 4'h9
`define CPU_OP_LLB 4'hA
`define CPU_OP_LHB 4'hB
`define CPU_OP_B 4'hC
`define CPU_OP_BR 4'hD
`define CPU_OP_HLT 4'hF

`define CPU_COND_NE 3'd0 // z clear
`define CPU_COND_EQ 3'd1 // z set
`define CPU_COND_GT 3'd2 // z and n clear
`define CPU_COND_LT 3'd3 // n set
`define CPU_COND_GE 3'd4 // z set or n clear
`define CPU_COND_LE 3'd5 // z or n set
`define CPU_COND_OV 3'd6 // v set
`define CPU_COND_UN 3'd7 // always

`define CPU_FLAG_Z 2 // flag bit positions in {z, v, n}
`define CPU_FLAG_V 1
`define CPU_FLAG_N 0

`endif
